//--- src/wasm_pkg.sv
/* wasm decoder constants */
`default_nettype none

package wasm_pkg;

    // window and field sizes
    localparam int WINDOW_BYTES  = 20;
    localparam int LEB_MAX_BYTES = 10;
    localparam int PC_W          = 32;
    localparam int IMM_W         = 64;
    localparam int LEN_W         = 8;
    localparam int KIND_W        = 3;

    // immediate kinds, one per operand layout
    localparam logic [KIND_W-1:0] KIND_NONE  = 3'd0;
    localparam logic [KIND_W-1:0] KIND_BLOCK = 3'd1;
    localparam logic [KIND_W-1:0] KIND_ULEB1 = 3'd2;
    localparam logic [KIND_W-1:0] KIND_SLEB1 = 3'd3;
    localparam logic [KIND_W-1:0] KIND_ULEB2 = 3'd4;
    localparam logic [KIND_W-1:0] KIND_BYTE  = 3'd5;
    localparam logic [KIND_W-1:0] KIND_F32   = 3'd6;
    localparam logic [KIND_W-1:0] KIND_F64   = 3'd7;

    // control flow
    localparam logic [7:0] OP_BLOCK         = 8'h02;
    localparam logic [7:0] OP_LOOP          = 8'h03;
    localparam logic [7:0] OP_IF            = 8'h04;
    localparam logic [7:0] OP_BR            = 8'h0c;
    localparam logic [7:0] OP_BR_IF         = 8'h0d;
    localparam logic [7:0] OP_CALL          = 8'h10;
    localparam logic [7:0] OP_CALL_INDIRECT = 8'h11;

    // variable and table access
    localparam logic [7:0] OP_LOCAL_GET     = 8'h20;
    localparam logic [7:0] OP_LOCAL_SET     = 8'h21;
    localparam logic [7:0] OP_LOCAL_TEE     = 8'h22;
    localparam logic [7:0] OP_GLOBAL_GET    = 8'h23;
    localparam logic [7:0] OP_GLOBAL_SET    = 8'h24;
    localparam logic [7:0] OP_TABLE_GET     = 8'h25;
    localparam logic [7:0] OP_TABLE_SET     = 8'h26;

    // memory: loads and stores form one contiguous range
    localparam logic [7:0] OP_LOAD_FIRST    = 8'h28;
    localparam logic [7:0] OP_STORE_LAST    = 8'h3e;
    localparam logic [7:0] OP_MEM_SIZE      = 8'h3f;
    localparam logic [7:0] OP_MEM_GROW      = 8'h40;

    // constants and references
    localparam logic [7:0] OP_I32_CONST     = 8'h41;
    localparam logic [7:0] OP_I64_CONST     = 8'h42;
    localparam logic [7:0] OP_F32_CONST     = 8'h43;
    localparam logic [7:0] OP_F64_CONST     = 8'h44;
    localparam logic [7:0] OP_REF_FUNC      = 8'hd2;

    // block type
    localparam logic [7:0]       BLOCK_EMPTY     = 8'h40;
    localparam logic [IMM_W-1:0] BLOCK_VOID_MARK = 64'h0000_0000_ffff_ffff;

endpackage

`default_nettype wire

//--- src/wasm_fetch_window.sv
/* instruction window input register */
`default_nettype none

module wasm_fetch_window (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid_in,
    input  logic [wasm_pkg::PC_W-1:0] pc,
    input  logic [7:0]                instr_bytes [0:wasm_pkg::WINDOW_BYTES-1],
    input  logic [4:0]                bytes_available,
    output logic                      win_valid,
    output logic [wasm_pkg::PC_W-1:0] win_pc,
    output logic [7:0]                win_bytes [0:wasm_pkg::WINDOW_BYTES-1]
);
    import wasm_pkg::*;

    logic accept;

    // an empty window carries no opcode, so it is dropped here
    assign accept = valid_in && (bytes_available != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= accept;
        end
    end

    // window and pc only load on an accepted item
    always_ff @(posedge clk) begin
        if (accept) begin
            win_pc <= pc;
            for (int i = 0; i < WINDOW_BYTES; i++) begin
                win_bytes[i] <= instr_bytes[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/wasm_opcode_classifier.sv
/* opcode to immediate kind */
`default_nettype none

module wasm_opcode_classifier (
    input  logic [7:0]                  opcode,
    output logic [wasm_pkg::KIND_W-1:0] kind,
    output logic                        is_signed
);
    import wasm_pkg::*;

    always_comb begin
        kind      = KIND_NONE;
        is_signed = 1'b0;

        case (opcode) inside
            // block type byte or type index
            OP_BLOCK, OP_LOOP, OP_IF: begin
                kind = KIND_BLOCK;
            end

            // single unsigned index
            OP_BR, OP_BR_IF, OP_CALL,
            OP_LOCAL_GET, OP_LOCAL_SET, OP_LOCAL_TEE,
            OP_GLOBAL_GET, OP_GLOBAL_SET,
            OP_TABLE_GET, OP_TABLE_SET,
            OP_REF_FUNC: begin
                kind = KIND_ULEB1;
            end

            // type and table index, or align and offset
            OP_CALL_INDIRECT, [OP_LOAD_FIRST:OP_STORE_LAST]: begin
                kind = KIND_ULEB2;
            end

            // memory index is a single raw byte
            OP_MEM_SIZE, OP_MEM_GROW: begin
                kind = KIND_BYTE;
            end

            OP_I32_CONST, OP_I64_CONST: begin
                kind      = KIND_SLEB1;
                is_signed = 1'b1;
            end

            OP_F32_CONST: begin
                kind = KIND_F32;
            end

            OP_F64_CONST: begin
                kind = KIND_F64;
            end

            // prefixes, br_table, select_t and the rest are one byte long
            default: begin
                kind = KIND_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/leb128_reader.sv
/* LEB128 field reader */
`default_nettype none

module leb128_reader (
    input  logic [7:0]                 field_bytes [0:wasm_pkg::LEB_MAX_BYTES-1],
    input  logic                       is_signed,
    output logic [wasm_pkg::IMM_W-1:0] value,
    output logic [3:0]                 byte_count
);
    import wasm_pkg::*;

    // ten groups of 7 bits overrun 64, upper bits are discarded
    logic [LEB_MAX_BYTES*7-1:0] acc;
    logic                       done;
    logic                       sign_bit;
    logic [6:0]                 shift;
    logic [IMM_W-1:0]           ext_mask;

    always_comb begin
        acc        = '0;
        done       = 1'b0;
        sign_bit   = 1'b0;
        byte_count = 4'd0;

        // least significant group first, stop after the byte with bit 7 clear
        for (int i = 0; i < LEB_MAX_BYTES; i++) begin
            if (!done) begin
                acc[i*7 +: 7] = field_bytes[i][6:0];
                byte_count    = 4'(i + 1);
                sign_bit      = field_bytes[i][6];
                if (!field_bytes[i][7]) begin
                    done = 1'b1;
                end
            end
        end
    end

    // bits above the last group, empty once the field covers all 64 bits
    assign shift    = 7'(byte_count) * 7'd7;
    assign ext_mask = {IMM_W{1'b1}} << shift;

    always_comb begin
        value = acc[IMM_W-1:0];
        if (is_signed && sign_bit) begin
            value = value | ext_mask;
        end
    end

endmodule

`default_nettype wire

//--- src/wasm_immediate_decode.sv
/* immediate and length decode */
`default_nettype none

module wasm_immediate_decode (
    input  logic                        win_valid,
    input  logic [wasm_pkg::PC_W-1:0]   win_pc,
    input  logic [7:0]                  win_bytes [0:wasm_pkg::WINDOW_BYTES-1],
    output logic                        dec_valid,
    output logic [wasm_pkg::PC_W-1:0]   dec_pc,
    output logic [7:0]                  dec_opcode,
    output logic [wasm_pkg::IMM_W-1:0]  dec_imm,
    output logic [wasm_pkg::IMM_W-1:0]  dec_imm2,
    output logic                        dec_has_imm,
    output logic                        dec_has_imm2,
    output logic [wasm_pkg::LEN_W-1:0]  dec_length
);
    import wasm_pkg::*;

    logic [KIND_W-1:0] kind;
    logic              is_signed;
    logic [7:0]        first_bytes  [0:LEB_MAX_BYTES-1];
    logic [7:0]        second_bytes [0:LEB_MAX_BYTES-1];
    logic [IMM_W-1:0]  first_value;
    logic [IMM_W-1:0]  second_value;
    logic [3:0]        first_count;
    logic [3:0]        second_count;
    logic [LEN_W-1:0]  first_len;
    logic [7:0]        type_byte;

    assign dec_valid  = win_valid;
    assign dec_pc     = win_pc;
    assign dec_opcode = win_bytes[0];
    assign type_byte  = win_bytes[1];

    wasm_opcode_classifier u_classifier (
        .opcode    (win_bytes[0]),
        .kind      (kind),
        .is_signed (is_signed)
    );

    // first field always starts right after the opcode
    for (genvar g = 0; g < LEB_MAX_BYTES; g++) begin : g_first_slice
        assign first_bytes[g] = win_bytes[g + 1];
    end

    // second field follows the first, reading zeros past the window end
    always_comb begin : second_slice
        int idx;
        for (int i = 0; i < LEB_MAX_BYTES; i++) begin
            idx = i + 1 + int'(first_count);
            second_bytes[i] = 8'h00;
            if (idx < WINDOW_BYTES) begin
                second_bytes[i] = win_bytes[idx];
            end
        end
    end

    leb128_reader first_field (
        .field_bytes (first_bytes),
        .is_signed   (is_signed),
        .value       (first_value),
        .byte_count  (first_count)
    );

    leb128_reader second_field (
        .field_bytes (second_bytes),
        .is_signed   (1'b0),
        .value       (second_value),
        .byte_count  (second_count)
    );

    assign first_len = LEN_W'(1) + LEN_W'(first_count);

    always_comb begin
        dec_imm      = '0;
        dec_imm2     = '0;
        dec_has_imm  = 1'b0;
        dec_has_imm2 = 1'b0;
        dec_length   = LEN_W'(1);

        case (kind)
            KIND_BLOCK: begin
                dec_has_imm = 1'b1;
                if (type_byte == BLOCK_EMPTY) begin
                    dec_imm    = BLOCK_VOID_MARK;
                    dec_length = LEN_W'(2);
                end else if (type_byte inside {[8'h7b:8'h7f], 8'h70, 8'h6f}) begin
                    // value type or funcref/externref
                    dec_imm    = IMM_W'(type_byte);
                    dec_length = LEN_W'(2);
                end else begin
                    dec_imm    = first_value;
                    dec_length = first_len;
                end
            end
            KIND_ULEB1, KIND_SLEB1: begin
                dec_imm     = first_value;
                dec_has_imm = 1'b1;
                dec_length  = first_len;
            end
            KIND_ULEB2: begin
                dec_imm      = first_value;
                dec_imm2     = second_value;
                dec_has_imm  = 1'b1;
                dec_has_imm2 = 1'b1;
                dec_length   = first_len + LEN_W'(second_count);
            end
            KIND_BYTE: begin
                dec_imm     = IMM_W'(win_bytes[1]);
                dec_has_imm = 1'b1;
                dec_length  = LEN_W'(2);
            end
            KIND_F32: begin
                dec_imm     = {32'h0, win_bytes[4], win_bytes[3], win_bytes[2], win_bytes[1]};
                dec_has_imm = 1'b1;
                dec_length  = LEN_W'(5);
            end
            KIND_F64: begin
                dec_imm     = {win_bytes[8], win_bytes[7], win_bytes[6], win_bytes[5],
                               win_bytes[4], win_bytes[3], win_bytes[2], win_bytes[1]};
                dec_has_imm = 1'b1;
                dec_length  = LEN_W'(9);
            end
            // KIND_NONE keeps the single-byte defaults
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/wasm_decode_output.sv
/* decoded result register */
`default_nettype none

module wasm_decode_output (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dec_valid,
    input  logic [wasm_pkg::PC_W-1:0]  dec_pc,
    input  logic [7:0]                 dec_opcode,
    input  logic [wasm_pkg::IMM_W-1:0] dec_imm,
    input  logic [wasm_pkg::IMM_W-1:0] dec_imm2,
    input  logic                       dec_has_imm,
    input  logic                       dec_has_imm2,
    input  logic [wasm_pkg::LEN_W-1:0] dec_length,
    output logic                       valid_out,
    output logic [7:0]                 opcode,
    output logic [wasm_pkg::IMM_W-1:0] immediate,
    output logic [wasm_pkg::IMM_W-1:0] immediate2,
    output logic                       has_immediate,
    output logic                       has_immediate2,
    output logic [wasm_pkg::LEN_W-1:0] instr_length,
    output logic [wasm_pkg::PC_W-1:0]  next_pc
);
    import wasm_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= dec_valid;
        end
    end

    // result holds its last value between valid cycles
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            opcode         <= dec_opcode;
            immediate      <= dec_imm;
            immediate2     <= dec_imm2;
            has_immediate  <= dec_has_imm;
            has_immediate2 <= dec_has_imm2;
            instr_length   <= dec_length;
            next_pc        <= dec_pc + PC_W'(dec_length);
        end
    end

endmodule

`default_nettype wire

//--- src/wasm_decoder.sv
/* wasm instruction decoder top */
`default_nettype none

module wasm_decoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid_in,
    input  logic [wasm_pkg::PC_W-1:0]  pc,
    input  logic [7:0]                 instr_bytes [0:wasm_pkg::WINDOW_BYTES-1],
    input  logic [4:0]                 bytes_available,
    output logic                       valid_out,
    output logic [7:0]                 opcode,
    output logic [wasm_pkg::IMM_W-1:0] immediate,
    output logic [wasm_pkg::IMM_W-1:0] immediate2,
    output logic                       has_immediate,
    output logic                       has_immediate2,
    output logic [wasm_pkg::LEN_W-1:0] instr_length,
    output logic [wasm_pkg::PC_W-1:0]  next_pc
);
    import wasm_pkg::*;

    // fetch window to decode
    logic              win_valid;
    logic [PC_W-1:0]   win_pc;
    logic [7:0]        win_bytes [0:WINDOW_BYTES-1];

    // decode to output register
    logic              dec_valid;
    logic [PC_W-1:0]   dec_pc;
    logic [7:0]        dec_opcode;
    logic [IMM_W-1:0]  dec_imm;
    logic [IMM_W-1:0]  dec_imm2;
    logic              dec_has_imm;
    logic              dec_has_imm2;
    logic [LEN_W-1:0]  dec_length;

    wasm_fetch_window u_fetch_window (
        .clk             (clk),
        .reset           (reset),
        .valid_in        (valid_in),
        .pc              (pc),
        .instr_bytes     (instr_bytes),
        .bytes_available (bytes_available),
        .win_valid       (win_valid),
        .win_pc          (win_pc),
        .win_bytes       (win_bytes)
    );

    wasm_immediate_decode u_immediate_decode (
        .win_valid    (win_valid),
        .win_pc       (win_pc),
        .win_bytes    (win_bytes),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_opcode   (dec_opcode),
        .dec_imm      (dec_imm),
        .dec_imm2     (dec_imm2),
        .dec_has_imm  (dec_has_imm),
        .dec_has_imm2 (dec_has_imm2),
        .dec_length   (dec_length)
    );

    wasm_decode_output u_decode_output (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_opcode     (dec_opcode),
        .dec_imm        (dec_imm),
        .dec_imm2       (dec_imm2),
        .dec_has_imm    (dec_has_imm),
        .dec_has_imm2   (dec_has_imm2),
        .dec_length     (dec_length),
        .valid_out      (valid_out),
        .opcode         (opcode),
        .immediate      (immediate),
        .immediate2     (immediate2),
        .has_immediate  (has_immediate),
        .has_immediate2 (has_immediate2),
        .instr_length   (instr_length),
        .next_pc        (next_pc)
    );

endmodule

`default_nettype wire

//--- tb/wasm_decoder_tb.sv
/* wasm decoder testbench */
`default_nettype none

module wasm_decoder_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import wasm_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;
    localparam int          N_ITEMS      = 400;
    localparam int          WATCHDOG_NS  = N_ITEMS * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h3b18_5b5c;

    // opcodes with no immediate, including dropped prefixes and reference ops
    localparam logic [7:0] PLAIN_OPS [0:15] = '{8'h00, 8'h01, 8'h05, 8'h0b, 8'h0e, 8'h0f,
        8'h1a, 8'h1b, 8'h1c, 8'h27, 8'h45, 8'h63, 8'hd0, 8'hd5, 8'hfc, 8'hfd};
    localparam logic [7:0] INDEX_OPS [0:10] = '{OP_BR, OP_BR_IF, OP_CALL, OP_LOCAL_GET,
        OP_LOCAL_SET, OP_LOCAL_TEE, OP_GLOBAL_GET, OP_GLOBAL_SET, OP_TABLE_GET,
        OP_TABLE_SET, OP_REF_FUNC};
    localparam logic [7:0] BLOCK_OPS [0:2]   = '{OP_BLOCK, OP_LOOP, OP_IF};
    localparam logic [7:0] VALUE_TYPES [0:6] = '{8'h7f, 8'h7e, 8'h7d, 8'h7c, 8'h7b, 8'h70, 8'h6f};

    typedef struct packed {
        logic [7:0]       opcode;
        logic [IMM_W-1:0] imm;
        logic [IMM_W-1:0] imm2;
        logic             has_imm;
        logic             has_imm2;
        logic [LEN_W-1:0] len;
        logic [PC_W-1:0]  next_pc;
        logic [31:0]      due_cycle;
    } result_t;

    logic             clk;
    logic             reset;
    logic             valid_in;
    logic [PC_W-1:0]  pc;
    logic [7:0]       instr_bytes [0:WINDOW_BYTES-1];
    logic [4:0]       bytes_available;
    logic             valid_out;
    logic [7:0]       opcode;
    logic [IMM_W-1:0] immediate;
    logic [IMM_W-1:0] immediate2;
    logic             has_immediate;
    logic             has_immediate2;
    logic [LEN_W-1:0] instr_length;
    logic [PC_W-1:0]  next_pc;

    logic [7:0]  enc_q [$];
    result_t     exp_q [$];
    int unsigned cycle = 0;
    int          accepted = 0;
    int          checked = 0;

    wasm_decoder u_wasm_decoder (
        .clk             (clk),
        .reset           (reset),
        .valid_in        (valid_in),
        .pc              (pc),
        .instr_bytes     (instr_bytes),
        .bytes_available (bytes_available),
        .valid_out       (valid_out),
        .opcode          (opcode),
        .immediate       (immediate),
        .immediate2      (immediate2),
        .has_immediate   (has_immediate),
        .has_immediate2  (has_immediate2),
        .instr_length    (instr_length),
        .next_pc         (next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_imm(input string name, input logic [IMM_W-1:0] got,
                             input logic [IMM_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_len(input string name, input logic [LEN_W-1:0] got,
                             input logic [LEN_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_pc(input string name, input logic [PC_W-1:0] got,
                            input logic [PC_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // minimal unsigned LEB128 with the low group first
    task automatic push_uleb(input logic [63:0] v);
        logic [63:0] rest;
        logic [7:0]  b;
        logic        more;
        rest = v;
        more = 1'b1;
        while (more) begin
            b    = {1'b0, rest[6:0]};
            rest = rest >> 7;
            more = (rest != 64'd0);
            b[7] = more;
            enc_q.push_back(b);
        end
    endtask

    // minimal signed LEB128 that stops once the sign bit covers the rest
    task automatic push_sleb(input longint v);
        longint     rest;
        logic [7:0] b;
        logic       more;
        rest = v;
        more = 1'b1;
        while (more) begin
            b    = {1'b0, rest[6:0]};
            rest = rest >>> 7;
            more = !((rest == 0 && !b[6]) || (rest == -1 && b[6]));
            b[7] = more;
            enc_q.push_back(b);
        end
    endtask

    // index of random length from 1 to 5 LEB bytes
    function automatic logic [63:0] rand_index();
        logic [31:0] w;
        w = $urandom() >> $urandom_range(31, 0);
        return {32'h0, w};
    endfunction

    task automatic encode_item(input logic [PC_W-1:0] item_pc, output result_t r);
        logic [7:0]  op;
        logic [63:0] a;
        logic [31:0] w32;
        int          s32;
        longint      sval;
        int          pick;
        enc_q.delete();
        r         = '0;
        r.has_imm = 1'b1;
        pick      = int'($urandom_range(6, 0));
        case (pick)
            0: begin
                op = PLAIN_OPS[int'($urandom_range(15, 0))];
                enc_q.push_back(op);
                r.has_imm = 1'b0;
            end
            1: begin
                op = INDEX_OPS[int'($urandom_range(10, 0))];
                a  = rand_index();
                enc_q.push_back(op);
                push_uleb(a);
                r.imm = a;
            end
            2: begin
                op = BLOCK_OPS[int'($urandom_range(2, 0))];
                enc_q.push_back(op);
                case ($urandom_range(2, 0))
                    0: begin
                        enc_q.push_back(BLOCK_EMPTY);
                        r.imm = BLOCK_VOID_MARK;
                    end
                    1: begin
                        w32 = {24'h0, VALUE_TYPES[int'($urandom_range(6, 0))]};
                        enc_q.push_back(w32[7:0]);
                        r.imm = {32'h0, w32};
                    end
                    default: begin
                        // one-byte indices from 64 up would collide with type bytes
                        a = rand_index();
                        if (a >= 64'd64 && a < 64'd128) begin
                            a = a - 64'd64;
                        end
                        push_uleb(a);
                        r.imm = a;
                    end
                endcase
            end
            3: begin
                if ($urandom_range(1, 0) == 0) begin
                    op   = OP_I32_CONST;
                    s32  = $signed($urandom()) >>> $urandom_range(31, 0);
                    sval = longint'(s32);
                end else begin
                    op   = OP_I64_CONST;
                    sval = $signed({$urandom(), $urandom()}) >>> $urandom_range(63, 0);
                end
                enc_q.push_back(op);
                push_sleb(sval);
                r.imm = sval;
            end
            4: begin
                if ($urandom_range(3, 0) == 0) begin
                    op = OP_CALL_INDIRECT;
                end else begin
                    op = 8'($urandom_range(int'(OP_STORE_LAST), int'(OP_LOAD_FIRST)));
                end
                enc_q.push_back(op);
                a = rand_index();
                push_uleb(a);
                r.imm = a;
                a = rand_index();
                push_uleb(a);
                r.imm2     = a;
                r.has_imm2 = 1'b1;
            end
            5: begin
                op  = ($urandom_range(1, 0) == 0) ? OP_MEM_SIZE : OP_MEM_GROW;
                w32 = {24'h0, 8'($urandom())};
                enc_q.push_back(op);
                enc_q.push_back(w32[7:0]);
                r.imm = {32'h0, w32};
            end
            default: begin
                a = {$urandom(), $urandom()};
                if ($urandom_range(1, 0) == 0) begin
                    op    = OP_F32_CONST;
                    a     = {32'h0, a[31:0]};
                    r.imm = a;
                    enc_q.push_back(op);
                    for (int i = 0; i < 4; i++) enc_q.push_back(a[i*8 +: 8]);
                end else begin
                    op    = OP_F64_CONST;
                    r.imm = a;
                    enc_q.push_back(op);
                    for (int i = 0; i < 8; i++) enc_q.push_back(a[i*8 +: 8]);
                end
            end
        endcase
        r.opcode  = op;
        r.len     = LEN_W'(enc_q.size());
        r.next_pc = item_pc + PC_W'(enc_q.size());
    endtask

    // valid item that is decoded 2 cycles after it is presented
    task automatic send_item();
        result_t         r;
        logic [PC_W-1:0] item_pc;
        @(posedge clk);
        #2;
        item_pc = $urandom();
        encode_item(item_pc, r);
        r.due_cycle = cycle + 2;
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            instr_bytes[i] = (i < enc_q.size()) ? enc_q[i] : 8'($urandom());
        end
        pc              = item_pc;
        valid_in        = 1'b1;
        bytes_available = 5'(enc_q.size());
        exp_q.push_back(r);
        accepted++;
    endtask

    // valid_in high with an empty window, or valid_in low
    task automatic send_dropped(input logic with_valid);
        @(posedge clk);
        #2;
        for (int i = 0; i < WINDOW_BYTES; i++) instr_bytes[i] = 8'($urandom());
        pc              = $urandom();
        valid_in        = with_valid;
        bytes_available = with_valid ? 5'd0 : 5'($urandom_range(20, 1));
    endtask

    always @(negedge clk) begin : check_results
        result_t e;
        if (valid_out) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: valid_out high at %0t with no item outstanding", $time);
                stop_on_failure();
            end else begin
                e = exp_q.pop_front();
                if (cycle != e.due_cycle) begin
                    $display("ERROR: result at cycle %0d, expected at %0d", cycle, e.due_cycle);
                    stop_on_failure();
                end
                check_byte("opcode", opcode, e.opcode);
                check_flag("has_immediate", has_immediate, e.has_imm);
                check_flag("has_immediate2", has_immediate2, e.has_imm2);
                if (e.has_imm) check_imm("immediate", immediate, e.imm);
                if (e.has_imm2) check_imm("immediate2", immediate2, e.imm2);
                check_len("instr_length", instr_length, e.len);
                check_pc("next_pc", next_pc, e.next_pc);
                checked++;
            end
        end else if (exp_q.size() != 0 && exp_q[0].due_cycle <= cycle) begin
            $display("ERROR: no valid_out for the item due at cycle %0d", exp_q[0].due_cycle);
            stop_on_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin
        void'($urandom(SEED));
        reset           = 1'b1;
        // a valid window is offered during reset and must not come out
        valid_in        = 1'b1;
        pc              = '0;
        bytes_available = 5'd4;
        for (int i = 0; i < WINDOW_BYTES; i++) instr_bytes[i] = 8'h00;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset    = 1'b0;
        valid_in = 1'b0;

        // mostly back-to-back, with idle and empty-window cycles mixed in
        for (int n = 0; n < N_ITEMS; n++) begin
            case ($urandom_range(7, 0))
                0: send_dropped(1'b0);
                1: send_dropped(1'b1);
                default: begin
                end
            endcase
            send_item();
        end
        send_dropped(1'b0);

        for (int i = 0; i < 8 && exp_q.size() != 0; i++) @(posedge clk);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() == 0) begin
            $display("%0d items checked", checked);
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d of %0d results never appeared", exp_q.size(), accepted);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

//--- tb.f
src/wasm_pkg.sv
src/wasm_fetch_window.sv
src/wasm_opcode_classifier.sv
src/leb128_reader.sv
src/wasm_immediate_decode.sv
src/wasm_decode_output.sv
src/wasm_decoder.sv
tb/wasm_decoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the wasm decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module wasm_decoder_tb -o wasm_decoder_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/wasm_decoder_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
